/* hdl/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

  // Command word layout
  localparam int CMD_W  = 16;
  localparam int DATA_W = 8;
  localparam int ADDR_W = 7;
  localparam int WR_BIT = 15;                // 1 = write, 0 = read

  // Line timing, kept short for simulation
  localparam int BAUD_DIV   = 16;            // Clocks per bit time
  localparam int BAUD_CNT_W = 4;
  localparam int GAP_BITS   = 2;             // Idle bit times after each tx frame
  localparam int FRAME_BITS = 11;            // Start, 8 data, parity, stop
  localparam int BIT_CNT_W  = 4;

  // Byte buffer between framer and transmitter
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;
  localparam int CNT_W      = FIFO_AW + 1;   // Holds 0 to FIFO_DEPTH

  localparam int ST_W = 2;

  // Framer states
  localparam logic [ST_W-1:0] FR_IDLE     = 2'd0;
  localparam logic [ST_W-1:0] FR_PUSH_LO  = 2'd1;
  localparam logic [ST_W-1:0] FR_WAIT_RSP = 2'd2;

  // Transmitter states
  localparam logic [ST_W-1:0] TX_IDLE  = 2'd0;
  localparam logic [ST_W-1:0] TX_FRAME = 2'd1;
  localparam logic [ST_W-1:0] TX_GAP   = 2'd2;

  // Receiver states
  localparam logic [ST_W-1:0] RX_IDLE  = 2'd0;
  localparam logic [ST_W-1:0] RX_START = 2'd1;
  localparam logic [ST_W-1:0] RX_DATA  = 2'd2;

endpackage

`default_nettype wire

/* hdl/cmd_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_framer import uart_cmd_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire  [CMD_W-1:0]  cmd_in,
  input  wire               cmd_vld,
  input  wire  [CNT_W-1:0]  free_cnt,
  input  wire               rx_done,
  output wire               cmd_rdy,
  output logic              push,
  output logic [DATA_W-1:0] push_data
);

  logic [ST_W-1:0]   state;
  logic [DATA_W-1:0] cmd_lo;   // Low byte of a write, pushed second
  logic              accept;

  // Wait response doubles as the pending-read flag
  assign cmd_rdy = (state == FR_IDLE) && !push && (free_cnt >= CNT_W'(2));
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= FR_IDLE;
      push  <= 1'b0;
    end
    else
    begin
      push <= 1'b0;
      case (state)
        FR_IDLE:
        begin
          if (accept)
          begin
            push  <= 1'b1;                 // High byte goes first
            state <= cmd_in[WR_BIT] ? FR_PUSH_LO : FR_WAIT_RSP;
          end
        end
        FR_PUSH_LO:
        begin
          push  <= 1'b1;
          state <= FR_IDLE;
        end
        FR_WAIT_RSP:
        begin
          if (rx_done)
            state <= FR_IDLE;              // Reply byte is back
        end
        default:
          state <= FR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_lo    <= cmd_in[DATA_W-1:0];
      push_data <= {cmd_in[WR_BIT], cmd_in[WR_BIT-1 -: ADDR_W]};
    end
    else if (state == FR_PUSH_LO)
    begin
      push_data <= cmd_lo;
    end
  end

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import uart_cmd_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               push,
  input  wire  [DATA_W-1:0] push_data,
  input  wire               pop,
  output logic [DATA_W-1:0] head_data,
  output logic              empty,
  output wire  [CNT_W-1:0]  free_cnt
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [CNT_W-1:0]   count;

  assign free_cnt = CNT_W'(FIFO_DEPTH) - count;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;          // Wraps with the depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Head is refetched for one cycle after a pop
      empty <= pop ? 1'b1 : (count == '0);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
    head_data <= mem[rd_ptr];              // Follows empty by construction
  end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_cmd_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              empty,
  input  wire [DATA_W-1:0] head_data,
  output wire              pop,
  output logic             tx,
  output wire              tx_busy
);

  logic [ST_W-1:0]       state;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_idx;
  logic [DATA_W+1:0]     shift;    // Stop, parity, data still to go
  logic                  bit_end;

  assign pop     = (state == TX_IDLE) && !empty;
  assign tx_busy = (state != TX_IDLE);
  assign bit_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      case (state)
        TX_IDLE:
        begin
          if (pop)
          begin
            state    <= TX_FRAME;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b0;              // Start bit
          end
        end
        TX_FRAME:
        begin
          baud_cnt <= baud_cnt + 1'b1;
          if (bit_end)
          begin
            baud_cnt <= '0;
            if (bit_idx == BIT_CNT_W'(FRAME_BITS - 1))
            begin
              state   <= TX_GAP;
              bit_idx <= '0;
              tx      <= 1'b1;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[0];
            end
          end
        end
        TX_GAP:
        begin
          baud_cnt <= baud_cnt + 1'b1;
          if (bit_end)
          begin
            baud_cnt <= '0;
            if (bit_idx == BIT_CNT_W'(GAP_BITS - 1))
              state <= TX_IDLE;
            else
              bit_idx <= bit_idx + 1'b1;
          end
        end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      shift <= {1'b1, ^head_data, head_data};    // Even parity
    else if ((state == TX_FRAME) && bit_end)
      shift <= {1'b1, shift[DATA_W+1:1]};
  end

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_cmd_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               rx,
  output logic              rx_done,
  output logic [DATA_W-1:0] rx_data,
  output logic              rx_err
);

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [ST_W-1:0]       state;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_idx;
  logic [DATA_W:0]       shreg;     // Parity and data, LSB first
  logic                  fall;
  logic                  half_end;
  logic                  bit_end;
  logic                  sample;
  logic                  last_bit;

  assign fall     = rx_prev && !rx_sync;
  assign half_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1));
  assign bit_end  = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign sample   = (state == RX_DATA) && bit_end;
  assign last_bit = (bit_idx == BIT_CNT_W'(FRAME_BITS - 2));   // Stop bit

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
      rx_err   <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          if (fall)
          begin
            state    <= RX_START;
            baud_cnt <= '0;
          end
        end
        RX_START:
        begin
          baud_cnt <= baud_cnt + 1'b1;
          if (half_end)
          begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch goes back to idle
          end
        end
        RX_DATA:
        begin
          baud_cnt <= baud_cnt + 1'b1;
          if (bit_end)
          begin
            baud_cnt <= '0;
            if (last_bit)
            begin
              state   <= RX_IDLE;
              rx_done <= 1'b1;
              rx_err  <= (^shreg) || !rx_sync;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && !last_bit)
      shreg <= {rx_sync, shreg[DATA_W:1]};
    if (sample && last_bit)
      rx_data <= shreg[DATA_W-1:0];
  end

endmodule

`default_nettype wire

/* hdl/uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top import uart_cmd_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  input  wire [CMD_W-1:0]  cmd_in,
  input  wire              cmd_vld,
  output wire              cmd_rdy,
  input  wire              rx,
  output wire              tx,
  output wire [DATA_W-1:0] read_data,
  output wire              read_rdy,
  output wire              read_err
);

  wire              push;
  wire [DATA_W-1:0] push_data;
  wire [CNT_W-1:0]  free_cnt;
  wire              empty;
  wire [DATA_W-1:0] head_data;
  wire              pop;
  wire              tx_busy;     // Frame plus gap in progress
  wire              rx_done;
  wire [DATA_W-1:0] rx_data;
  wire              rx_err;

  cmd_framer u_framer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .free_cnt  (free_cnt),
    .rx_done   (rx_done),
    .cmd_rdy   (cmd_rdy),
    .push      (push),
    .push_data (push_data)
  );

  byte_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .head_data (head_data),
    .empty     (empty),
    .free_cnt  (free_cnt)
  );

  uart_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .empty     (empty),
    .head_data (head_data),
    .pop       (pop),
    .tx        (tx),
    .tx_busy   (tx_busy)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_done   (rx_done),
    .rx_data   (rx_data),
    .rx_err    (rx_err)
  );

  assign read_data = rx_data;
  assign read_rdy  = rx_done;
  assign read_err  = rx_err;

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk
);

  localparam int HALF_NS = 50;   // 100 ns period

  initial
  begin
    clk = 1'b0;
    forever
      #HALF_NS clk = ~clk;
  end

endmodule

`default_nettype wire

/* bench/uart_cmd_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_chk import uart_cmd_pkg::*; (
  input wire             clk,
  input wire             rst_n,
  input wire             cmd_vld,
  input wire             cmd_rdy,
  input wire             tx,
  input wire             read_rdy,
  input wire             read_err,
  input wire             push,
  input wire [CNT_W-1:0] free_cnt,
  input wire             tx_busy
);

  int fail_cnt = 0;   // Failed assertions so far

  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (tx && cmd_rdy && !read_rdy && !read_err))
    else
    begin
      fail_cnt++;
      $error("outputs were not at their idle values when reset ended");
    end

  read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else
    begin
      fail_cnt++;
      $error("read_rdy stayed high for two cycles in a row");
    end

  // Both bytes of a write must fit behind the ones already queued
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (free_cnt != '0))
    else
    begin
      fail_cnt++;
      $error("a byte was pushed into a full FIFO");
    end

  ignored_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && !cmd_rdy && !push) |=> !push)
    else
    begin
      fail_cnt++;
      $error("a command offered while cmd_rdy was low reached the FIFO");
    end

  line_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else
    begin
      fail_cnt++;
      $error("tx was low while the transmitter was idle");
    end

endmodule

`default_nettype wire

/* bench/uart_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_tb import uart_cmd_pkg::*; ();

  localparam logic [31:0] SEED = 32'h5d03;
  localparam int N_WR      = 8;
  localparam int N_RD      = 4;    // Odd reads get a reply with bad parity
  localparam int N_BURST   = 10;
  localparam int N_CMDS    = N_WR + N_RD + N_BURST;
  localparam int WD_CYCLES = N_CMDS * 3 * (FRAME_BITS + GAP_BITS) * BAUD_DIV + 5000;
  localparam int MIN_IDLE  = BAUD_DIV - BAUD_DIV / 2 - 1 + GAP_BITS * BAUD_DIV;

  wire               clk;
  logic              rst_n;
  logic [CMD_W-1:0]  cmd_in;
  logic              cmd_vld;
  wire               cmd_rdy;
  logic              rx;
  wire               tx;
  wire  [DATA_W-1:0] read_data;
  wire               read_rdy;
  wire               read_err;

  logic [DATA_W-1:0] exp_q[$];   // Bytes due on tx, oldest first
  int                err_cnt;
  int                bytes_sent;
  int                bytes_seen;
  int                stall_cycles;
  logic              rsp_seen;
  logic [DATA_W-1:0] rsp_data;
  logic              rsp_err;

  clk_gen u_clk (
    .clk (clk)
  );

  uart_cmd_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  bind uart_cmd_top uart_cmd_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_err (read_err),
    .push     (push),
    .free_cnt (free_cnt),
    .tx_busy  (tx_busy)
  );

  function automatic void flag_mismatch(input string msg);
    err_cnt++;
    $display("Error %0t: %s", $time, msg);
  endfunction

  // Called once per falling edge while a read is open
  function automatic void watch_read();
    if (read_rdy && !rsp_seen)
    begin
      rsp_seen = 1'b1;
      rsp_data = read_data;
      rsp_err  = read_err;
    end
    else if (!rsp_seen)
      assert (!cmd_rdy) else flag_mismatch("cmd_rdy is high while a read is pending");
  endfunction

  task automatic issue_cmd(input logic [CMD_W-1:0] cmd);
    begin
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      while (!cmd_rdy)
      begin
        stall_cycles++;
        @(negedge clk);
      end
      exp_q.push_back(cmd[CMD_W-1 -: DATA_W]);   // Taken at the coming rising edge
      bytes_sent++;
      if (cmd[WR_BIT])
      begin
        exp_q.push_back(cmd[DATA_W-1:0]);
        bytes_sent++;
      end
      @(negedge clk);
    end
  endtask

  task automatic send_rx_frame(input logic [DATA_W-1:0] b, input logic bad_par);
    logic [FRAME_BITS-1:0] bits;
    int                    i;
    begin
      bits = {1'b1, (^b) ^ bad_par, b, 1'b0};   // Stop, parity, data, start
      for (i = 0; i < FRAME_BITS; i++)
      begin
        rx = bits[i];
        repeat (BAUD_DIV)
        begin
          @(negedge clk);
          watch_read();
        end
      end
    end
  endtask

  task automatic run_read(input logic bad_par);
    logic [DATA_W-1:0] reply;
    begin
      reply = DATA_W'($urandom);
      issue_cmd({1'b0, ADDR_W'($urandom), DATA_W'($urandom)});
      cmd_vld  = 1'b0;
      rsp_seen = 1'b0;
      while (exp_q.size() != 0)
      begin
        watch_read();
        @(negedge clk);
      end
      send_rx_frame(reply, bad_par);
      while (!rsp_seen)
      begin
        @(negedge clk);
        watch_read();
      end
      assert (rsp_err === bad_par)
        else flag_mismatch($sformatf("read_err is %b, expected %b", rsp_err, bad_par));
      if (!bad_par)
        assert (rsp_data === reply)
          else flag_mismatch($sformatf("read_data is %h, expected %h", rsp_data, reply));
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  // tx line model, sampled mid bit on falling edges
  initial
  begin
    int                idle_cnt;
    int                i;
    logic              first_frame;
    logic [DATA_W-1:0] data;
    logic              par;
    logic              stop_bit;
    logic [DATA_W-1:0] want;
    first_frame = 1'b1;
    @(posedge rst_n);
    forever
    begin
      idle_cnt = 0;
      @(negedge clk);
      while (tx !== 1'b0)
      begin
        idle_cnt++;
        @(negedge clk);
      end
      if (!first_frame)
        assert (idle_cnt >= MIN_IDLE)
          else flag_mismatch($sformatf("tx idle gap of %0d cycles is too short", idle_cnt));
      first_frame = 1'b0;
      repeat (BAUD_DIV / 2) @(negedge clk);
      assert (tx === 1'b0) else flag_mismatch("start bit on tx is not low at mid bit");
      for (i = 0; i < DATA_W; i++)
      begin
        repeat (BAUD_DIV) @(negedge clk);
        data[i] = tx;
      end
      repeat (BAUD_DIV) @(negedge clk);
      par = tx;
      repeat (BAUD_DIV) @(negedge clk);
      stop_bit = tx;
      bytes_seen++;
      assert (par === ^data) else flag_mismatch($sformatf("odd parity on tx byte %h", data));
      assert (stop_bit === 1'b1) else flag_mismatch("stop bit on tx is low");
      if (exp_q.size() == 0)
        flag_mismatch($sformatf("tx frame %h arrived with no byte expected", data));
      else
      begin
        want = exp_q.pop_front();
        assert (data === want)
          else flag_mismatch($sformatf("tx byte is %h, expected %h", data, want));
      end
    end
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    int i;
    int chk_cnt;
    void'($urandom(SEED));
    err_cnt      = 0;
    bytes_sent   = 0;
    bytes_seen   = 0;
    stall_cycles = 0;
    rsp_seen     = 1'b0;
    rsp_data     = '0;
    rsp_err      = 1'b0;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rx           = 1'b1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (i = 0; i < N_WR; i++)
    begin
      issue_cmd({1'b1, 15'($urandom)});
      cmd_vld = 1'b0;
      repeat ($urandom_range(0, 400)) @(negedge clk);
    end
    wait_drain();

    for (i = 0; i < N_RD; i++)
      run_read(1'(i % 2));

    // Writes offered back to back, FIFO fills up
    for (i = 0; i < N_BURST; i++)
      issue_cmd({1'b1, 15'($urandom)});
    cmd_vld = 1'b0;
    wait_drain();
    repeat ((FRAME_BITS + GAP_BITS) * BAUD_DIV) @(negedge clk);

    assert (bytes_seen == bytes_sent)
      else flag_mismatch($sformatf("%0d tx bytes seen, %0d sent", bytes_seen, bytes_sent));
    assert (stall_cycles > 0) else flag_mismatch("cmd_rdy never dropped while a command waited");
    chk_cnt = UUT.u_chk.fail_cnt;
    $display("Errors: %0d in data checks, %0d in protocol assertions", err_cnt, chk_cnt);
    if ((err_cnt == 0) && (chk_cnt == 0))
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/uart_cmd_pkg.sv
hdl/cmd_framer.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_cmd_top.sv
bench/clk_gen.sv
bench/uart_cmd_chk.sv
bench/uart_cmd_tb.sv

/* Makefile */
# Verilator build and run of the UART command bridge testbench

VERILATOR ?= verilator
TOP       ?= uart_cmd_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qxF '$(PASS_MSG)' $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
